/* commitCore.f */
+incdir+rtl
rtl/commitPkg.sv
rtl/robHeadIf.sv
rtl/renameCommitIf.sv
rtl/robQueue.sv
rtl/interruptSampler.sv
rtl/commitControl.sv
rtl/archRegCommit.sv
rtl/commitTop.sv
verification/commitChecker.sv
verification/commitTb.sv

/* Makefile */
# Verilator build and run for the commit stage.

VERILATOR ?= verilator
TOP       ?= commitTb
RTL_TOP   ?= commitTop
FILELIST  ?= commitCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/commitTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "commit_macros.svh"

module commitTb;

    localparam int NUM_TESTS = 6;
    localparam int OPS = 200;

    logic clk, rst;
    logic enqValid, enqIsBranch, enqPredTaken, enqDstWe;
    logic [31:0] enqPc, enqPredTarget;
    commitPkg::archReg_t enqDstArch;
    commitPkg::physReg_t enqDstPhys, freePhys0, freePhys1;
    commitPkg::robTag_t enqTag, cmpTag;
    logic robFull, cmpValid, cmpTaken;
    logic [31:0] cmpTarget, retirePc0, retirePc1, redirectPc, excPc;
    commitPkg::excCode_t cmpExc, excCode;
    logic [5:0] extInt, statusIm;
    logic statusIe, statusExl;
    logic retireValid0, retireValid1, freeValid0, freeValid1;
    logic flush, redirectValid, excValid;
    int errors, depth;
    int tbErrors = 0;
    int lastErrors = 0;
    int failedTests = 0;
    logic tagBranch [`ROB_DEPTH];
    logic tagPredTaken [`ROB_DEPTH];
    logic [31:0] tagPredTarget [`ROB_DEPTH];
    int unsigned outstanding[$];
    logic [31:0] pcNext = 32'h0040_0000;

    commitTop dut0 (.*);
    commitChecker check0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        $display("Watchdog timeout after %0d cycles, run did not finish", NUM_TESTS * 2000);
        $display("TEST FAILED");
        $finish;
    end

    task automatic completeOp(input int unsigned t, input int misPct, input int excPct);
        logic taken;
        logic [31:0] target;
        taken = tagBranch[t] && tagPredTaken[t];
        target = tagBranch[t] ? tagPredTarget[t] : 32'd0;
        if (tagBranch[t] && $urandom_range(99) < misPct) begin
            if (taken && $urandom_range(1) == 1) target = target + 32'h40;
            else taken = !taken;
        end
        cmpValid <= 1'b1;
        cmpTag <= commitPkg::robTag_t'(t);
        cmpTaken <= taken;
        cmpTarget <= target;
        cmpExc <= commitPkg::excNone;
        if ($urandom_range(99) < excPct) begin
            case ($urandom_range(2))
                0: cmpExc <= commitPkg::excSyscall;
                1: cmpExc <= commitPkg::excOverflow;
                default: cmpExc <= commitPkg::excAddrErr;
            endcase
        end
    endtask

    // Interrupt modes: 0 off, 1 taken, 2 masked, 3 disabled, 4 exception level.
    task automatic driveOps(input int nOps, input int misPct, input int excPct,
                            input int intMode, input int archMax);
        int sent;
        int idle;
        int k;
        int unsigned t;
        sent = 0;
        idle = 0;
        statusIm <= (intMode == 2) ? 6'h0F : 6'h3F;
        statusIe <= (intMode == 1 || intMode == 2 || intMode == 4);
        statusExl <= (intMode == 4);
        while (sent < nOps || idle < 12) begin
            @(posedge clk);
            if (flush) outstanding.delete();
            // The enqueue driven last cycle is taken at this edge.
            if (enqValid) begin
                t = 32'(enqTag);
                tagBranch[t] = enqIsBranch;
                tagPredTaken[t] = enqPredTaken;
                tagPredTarget[t] = enqPredTarget;
                outstanding.push_back(t);
            end
            idle = (sent >= nOps && outstanding.size() == 0 && !enqValid) ? idle + 1 : 0;
            enqValid <= 1'b0;
            cmpValid <= 1'b0;
            extInt <= '0;
            if (sent < nOps && !enqValid && !robFull) begin
                enqValid <= 1'b1;
                enqPc <= pcNext;
                pcNext = pcNext + 32'd4;
                enqIsBranch <= ($urandom_range(3) == 0);
                enqPredTaken <= 1'($urandom_range(1));
                enqPredTarget <= $urandom_range(32'hFFFF) << 2;
                enqDstWe <= ($urandom_range(4) != 0);
                enqDstArch <= commitPkg::archReg_t'($urandom_range(archMax));
                enqDstPhys <= commitPkg::physReg_t'($urandom_range(63));
                sent++;
            end
            if (outstanding.size() > 0 && $urandom_range(99) < 60) begin
                k = $urandom_range(outstanding.size() - 1);
                t = outstanding[k];
                outstanding.delete(k);
                completeOp(t, misPct, excPct);
            end
            if (intMode != 0 && $urandom_range(99) < 3) begin
                extInt <= (intMode == 2) ? 6'h30 : 6'h3F;
            end
        end
        statusIe <= 1'b0;
        statusExl <= 1'b0;
    endtask

    task automatic endTest(input string name);
        int now;
        now = errors + tbErrors;
        if (depth != 0) begin
            tbErrors++;
            now++;
            $display("%s: reorder buffer still holds %0d entries after drain", name, depth);
        end
        if (now != lastErrors) failedTests++;
        $display("%-20s %s (%0d errors)", name, (now == lastErrors) ? "passed" : "failed",
                 now - lastErrors);
        lastErrors = now;
    endtask

    initial begin
        void'($urandom(32'hcead));
        rst = 1'b1;
        {enqValid, enqIsBranch, enqPredTaken, enqDstWe, enqPc, enqPredTarget} = '0;
        enqDstArch = '0;
        enqDstPhys = '0;
        {cmpValid, cmpTag, cmpTaken, cmpTarget} = '0;
        cmpExc = commitPkg::excNone;
        {extInt, statusIm, statusIe, statusExl} = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        driveOps(0, 0, 0, 0, 31);
        endTest("reset state");
        driveOps(OPS, 0, 0, 0, 31);
        endTest("in-order retire");
        driveOps(OPS, 0, 0, 0, 3);
        endTest("free-list release");
        driveOps(OPS, 20, 0, 0, 31);
        endTest("branch mispredict");
        driveOps(OPS, 20, 5, 0, 31);
        endTest("exceptions");
        for (int m = 1; m <= 4; m++) driveOps(OPS / 4, 0, 0, m, 31);
        endTest("interrupt masking");
        $display("Tests run %0d, failed %0d, errors %0d", NUM_TESTS, failedTests,
                 errors + tbErrors);
        if (failedTests == 0 && errors + tbErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/commitChecker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "commit_macros.svh"

module commitChecker (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  enqValid,
    input  wire [31:0]           enqPc,
    input  wire                  enqIsBranch,
    input  wire                  enqPredTaken,
    input  wire [31:0]           enqPredTarget,
    input  wire                  enqDstWe,
    input  wire commitPkg::archReg_t enqDstArch,
    input  wire commitPkg::physReg_t enqDstPhys,
    input  wire commitPkg::robTag_t  enqTag,
    input  wire                  robFull,
    input  wire                  cmpValid,
    input  wire commitPkg::robTag_t  cmpTag,
    input  wire                  cmpTaken,
    input  wire [31:0]           cmpTarget,
    input  wire commitPkg::excCode_t cmpExc,
    input  wire [5:0]            extInt,
    input  wire [5:0]            statusIm,
    input  wire                  statusIe,
    input  wire                  statusExl,
    input  wire                  retireValid0,
    input  wire                  retireValid1,
    input  wire [31:0]           retirePc0,
    input  wire [31:0]           retirePc1,
    input  wire                  freeValid0,
    input  wire commitPkg::physReg_t freePhys0,
    input  wire                  freeValid1,
    input  wire commitPkg::physReg_t freePhys1,
    input  wire                  flush,
    input  wire                  redirectValid,
    input  wire [31:0]           redirectPc,
    input  wire                  excValid,
    input  wire commitPkg::excCode_t excCode,
    input  wire [31:0]           excPc,
    output int                   errors,
    output int                   depth
);

    commitPkg::robEntry_t q[$];
    commitPkg::robTag_t   tagQ[$];
    commitPkg::physReg_t  map [`ARCH_REGS];
    commitPkg::robTag_t   tail;
    logic                 intQ;
    logic                 armed = 1'b0;
    logic                 eR0, eR1, eFlush, eExc;
    logic [31:0]          ePc0, ePc1, eRedirPc, eExcPc;
    commitPkg::excCode_t  eCode;
    // Free-list expectations run one stage behind the retire ones.
    logic                 fV0A, fV1A, fV0B, fV1B;
    commitPkg::physReg_t  fP0A, fP1A, fP0B, fP1B;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH time=%0t %s expected=%h got=%h", $time, name, exp, got);
        end
    endtask

    always @(negedge clk) begin : model
        commitPkg::robEntry_t h0;
        commitPkg::robEntry_t h1;
        commitPkg::robEntry_t last;
        logic intTake, exc0, r0, r1, mis, full;
        if (armed) begin
            check("enqTag", enqTag, tail);
            check("robFull", robFull, q.size() == `ROB_DEPTH);
            check("retireValid0", retireValid0, eR0);
            check("retireValid1", retireValid1, eR1);
            if (eR0) check("retirePc0", retirePc0, ePc0);
            if (eR1) check("retirePc1", retirePc1, ePc1);
            check("flush", flush, eFlush);
            check("redirectValid", redirectValid, eFlush);
            if (eFlush) check("redirectPc", redirectPc, eRedirPc);
            check("excValid", excValid, eExc);
            check("excCode", excCode, eCode);
            if (eExc) check("excPc", excPc, eExcPc);
            check("freeValid0", freeValid0, fV0B);
            check("freeValid1", freeValid1, fV1B);
            if (fV0B) check("freePhys0", freePhys0, fP0B);
            if (fV1B) check("freePhys1", freePhys1, fP1B);
        end
        {fV0B, fV1B, fP0B, fP1B} = {fV0A, fV1A, fP0A, fP1A};
        {fV0A, fV1A, fP0A, fP1A} = '0;
        if (rst) begin
            q.delete();
            tagQ.delete();
            tail = '0;
            intQ = 1'b0;
            for (int i = 0; i < `ARCH_REGS; i++) map[i] = commitPkg::physReg_t'(i);
            {eR0, eR1, eFlush, eExc, ePc0, ePc1, eRedirPc, eExcPc} = '0;
            eCode = commitPkg::excNone;
            armed = 1'b1;
        end else begin
            h0 = (q.size() > 0) ? q[0] : '0;
            h1 = (q.size() > 1) ? q[1] : '0;
            full = (q.size() == `ROB_DEPTH);
            intTake = intQ && (q.size() > 0);
            exc0 = (q.size() > 0) && h0.done && (h0.exc != commitPkg::excNone) && !intTake;
            r0 = (q.size() > 0) && h0.done && (h0.exc == commitPkg::excNone) && !intTake;
            r1 = r0 && (q.size() > 1) && h1.done && (h1.exc == commitPkg::excNone)
                && !h0.isBranch;
            last = r1 ? h1 : h0;
            mis = r0 && last.isBranch && ((last.actualTaken != last.predTaken)
                || (last.actualTaken && last.predTaken && last.actualTarget != last.predTarget));
            eR0 = r0;
            eR1 = r1;
            ePc0 = h0.pc;
            ePc1 = h1.pc;
            eFlush = intTake || exc0 || mis;
            eExc = intTake || exc0;
            eExcPc = h0.pc;
            eCode = intTake ? commitPkg::excInterrupt : (exc0 ? h0.exc : commitPkg::excNone);
            eRedirPc = eExc ? `EXC_VECTOR
                : (last.actualTaken ? last.actualTarget : last.pc + 32'd8);
            // Slot 1 reads the map after slot 0 has written it.
            if (r0 && h0.dstWe) begin
                fV0A = 1'b1;
                fP0A = map[h0.dstArch];
                map[h0.dstArch] = h0.dstPhys;
            end
            if (r1 && h1.dstWe) begin
                fV1A = 1'b1;
                fP1A = map[h1.dstArch];
                map[h1.dstArch] = h1.dstPhys;
            end
            if (cmpValid && !eFlush) begin
                foreach (tagQ[i]) begin
                    if (tagQ[i] == cmpTag) begin
                        q[i].done = 1'b1;
                        q[i].actualTaken = cmpTaken;
                        q[i].actualTarget = cmpTarget;
                        q[i].exc = cmpExc;
                    end
                end
            end
            if (eFlush) begin
                q.delete();
                tagQ.delete();
                tail = '0;
            end else begin
                repeat (int'(r0) + int'(r1)) begin
                    void'(q.pop_front());
                    void'(tagQ.pop_front());
                end
                if (enqValid && !full) begin
                    q.push_back('{valid: 1'b1, done: 1'b0, pc: enqPc, isBranch: enqIsBranch,
                        predTaken: enqPredTaken, predTarget: enqPredTarget,
                        actualTaken: 1'b0, actualTarget: 32'd0, dstWe: enqDstWe,
                        dstArch: enqDstArch, dstPhys: enqDstPhys, exc: commitPkg::excNone});
                    tagQ.push_back(tail);
                    tail = tail + 1'b1;
                end
            end
            intQ = statusIe && !statusExl && (|(extInt & statusIm));
        end
        depth = q.size();
    end

endmodule

`default_nettype wire

/* rtl/commitTop.sv */
`timescale 1ns/1ps
`default_nettype none

module commitTop (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         enqValid,
    input  wire [31:0]                  enqPc,
    input  wire                         enqIsBranch,
    input  wire                         enqPredTaken,
    input  wire [31:0]                  enqPredTarget,
    input  wire                         enqDstWe,
    input  wire commitPkg::archReg_t    enqDstArch,
    input  wire commitPkg::physReg_t    enqDstPhys,
    output commitPkg::robTag_t          enqTag,
    output logic                        robFull,
    input  wire                         cmpValid,
    input  wire commitPkg::robTag_t     cmpTag,
    input  wire                         cmpTaken,
    input  wire [31:0]                  cmpTarget,
    input  wire commitPkg::excCode_t    cmpExc,
    input  wire [5:0]                   extInt,
    input  wire [5:0]                   statusIm,
    input  wire                         statusIe,
    input  wire                         statusExl,
    output logic                        retireValid0,
    output logic                        retireValid1,
    output logic [31:0]                 retirePc0,
    output logic [31:0]                 retirePc1,
    output logic                        freeValid0,
    output commitPkg::physReg_t         freePhys0,
    output logic                        freeValid1,
    output commitPkg::physReg_t         freePhys1,
    output logic                        flush,
    output logic                        redirectValid,
    output logic [31:0]                 redirectPc,
    output logic                        excValid,
    output commitPkg::excCode_t         excCode,
    output logic [31:0]                 excPc
);

    commitPkg::robEntry_t enqEntry;
    logic                 intPending;

    robHeadIf      headBus ();
    renameCommitIf renameBus ();

    // New entries start not done.
    assign enqEntry = '{valid: 1'b1, done: 1'b0, pc: enqPc, isBranch: enqIsBranch,
                        predTaken: enqPredTaken, predTarget: enqPredTarget,
                        actualTaken: 1'b0, actualTarget: 32'd0, dstWe: enqDstWe,
                        dstArch: enqDstArch, dstPhys: enqDstPhys,
                        exc: commitPkg::excNone};

    robQueue rob0 (
        .clk(clk), .rst(rst), .enqValid(enqValid), .enqEntry(enqEntry),
        .enqTag(enqTag), .robFull(robFull), .cmpValid(cmpValid), .cmpTag(cmpTag),
        .cmpTaken(cmpTaken), .cmpTarget(cmpTarget), .cmpExc(cmpExc), .head(headBus.rob)
    );

    interruptSampler int0 (
        .clk(clk), .rst(rst), .extInt(extInt), .statusIm(statusIm),
        .statusIe(statusIe), .statusExl(statusExl), .intPending(intPending)
    );

    commitControl ctrl0 (
        .clk(clk), .rst(rst), .head(headBus.ctrl), .intPending(intPending),
        .rename(renameBus.ctrl), .retireValid0(retireValid0), .retireValid1(retireValid1),
        .retirePc0(retirePc0), .retirePc1(retirePc1), .flush(flush),
        .redirectValid(redirectValid), .redirectPc(redirectPc), .excValid(excValid),
        .excCode(excCode), .excPc(excPc)
    );

    archRegCommit map0 (
        .clk(clk), .rst(rst), .rename(renameBus.map),
        .freeValid0(freeValid0), .freePhys0(freePhys0),
        .freeValid1(freeValid1), .freePhys1(freePhys1)
    );

endmodule

`default_nettype wire

/* rtl/archRegCommit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "commit_macros.svh"

module archRegCommit (
    input  wire                  clk,
    input  wire                  rst,
    renameCommitIf.map           rename,
    output logic                 freeValid0,
    output commitPkg::physReg_t  freePhys0,
    output logic                 freeValid1,
    output commitPkg::physReg_t  freePhys1
);

    commitPkg::physReg_t map [`ARCH_REGS];
    commitPkg::physReg_t old0;
    commitPkg::physReg_t old1;
    logic                write0;
    logic                write1;

    assign write0 = rename.slot0.valid && rename.slot0.we;
    assign write1 = rename.slot1.valid && rename.slot1.we;

    assign old0 = map[rename.slot0.arch];
    // Same register in both slots frees slot 0's new mapping.
    assign old1 = (write0 && (rename.slot0.arch == rename.slot1.arch))
                ? rename.slot0.phys : map[rename.slot1.arch];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map[i] <= commitPkg::physReg_t'(i);
            end
            freeValid0 <= 1'b0;
            freeValid1 <= 1'b0;
            freePhys0  <= '0;
            freePhys1  <= '0;
        end else begin
            if (write0) begin
                map[rename.slot0.arch] <= rename.slot0.phys;
            end
            // Later write wins.
            if (write1) begin
                map[rename.slot1.arch] <= rename.slot1.phys;
            end
            freeValid0 <= write0;
            freeValid1 <= write1;
            freePhys0  <= old0;
            freePhys1  <= old1;
        end
    end

endmodule

`default_nettype wire

/* rtl/commitControl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "commit_macros.svh"

module commitControl (
    input  wire                  clk,
    input  wire                  rst,
    robHeadIf.ctrl               head,
    input  wire                  intPending,
    renameCommitIf.ctrl          rename,
    output logic                 retireValid0,
    output logic                 retireValid1,
    output logic [31:0]          retirePc0,
    output logic [31:0]          retirePc1,
    output logic                 flush,
    output logic                 redirectValid,
    output logic [31:0]          redirectPc,
    output logic                 excValid,
    output commitPkg::excCode_t  excCode,
    output logic [31:0]          excPc
);

    commitPkg::robEntry_t    lastEntry;
    commitPkg::retireSlot_t  slot0Q;
    commitPkg::retireSlot_t  slot1Q;
    logic                    head0Ok;
    logic                    intTake;
    logic                    exc0;
    logic                    retire0;
    logic                    retire1;
    logic                    takenWrong;
    logic                    targetWrong;
    logic                    mispredict;
    logic                    flushNow;
    logic [31:0]             correctPc;

    assign head0Ok = head.head0Valid && head.head0.done;
    assign intTake = intPending && head.head0Valid;
    assign exc0    = head0Ok && (head.head0.exc != commitPkg::excNone) && !intTake;
    assign retire0 = head0Ok && (head.head0.exc == commitPkg::excNone) && !intTake;

    // A branch never has a partner after it in the same cycle.
    assign retire1 = retire0 && head.head1Valid && head.head1.done
                  && (head.head1.exc == commitPkg::excNone) && !head.head0.isBranch;

    assign lastEntry   = retire1 ? head.head1 : head.head0;
    assign takenWrong  = lastEntry.actualTaken != lastEntry.predTaken;
    assign targetWrong = lastEntry.actualTaken && lastEntry.predTaken
                      && (lastEntry.actualTarget != lastEntry.predTarget);
    assign mispredict  = retire0 && lastEntry.isBranch && (takenWrong || targetWrong);
    assign correctPc   = lastEntry.actualTaken ? lastEntry.actualTarget
                                               : lastEntry.pc + 32'd8;

    assign flushNow         = intTake || exc0 || mispredict;
    assign head.flush       = flushNow;
    assign head.retireCount = {retire1, retire0 && !retire1};

    always_ff @(posedge clk) begin
        if (rst) begin
            slot0Q        <= '0;
            slot1Q        <= '0;
            retirePc0     <= '0;
            retirePc1     <= '0;
            flush         <= 1'b0;
            redirectValid <= 1'b0;
            redirectPc    <= '0;
            excValid      <= 1'b0;
            excCode       <= commitPkg::excNone;
            excPc         <= '0;
        end else begin
            slot0Q <= '{valid: retire0, we: head.head0.dstWe,
                        arch: head.head0.dstArch, phys: head.head0.dstPhys};
            slot1Q <= '{valid: retire1, we: head.head1.dstWe,
                        arch: head.head1.dstArch, phys: head.head1.dstPhys};
            retirePc0     <= head.head0.pc;
            retirePc1     <= head.head1.pc;
            flush         <= flushNow;
            redirectValid <= flushNow;
            // Exceptions go to the vector, mispredictions to the correct path.
            redirectPc    <= (intTake || exc0) ? `EXC_VECTOR : correctPc;
            excValid      <= intTake || exc0;
            if (intTake) begin
                excCode <= commitPkg::excInterrupt;
            end else if (exc0) begin
                excCode <= head.head0.exc;
            end else begin
                excCode <= commitPkg::excNone;
            end
            excPc <= head.head0.pc;
        end
    end

    assign retireValid0 = slot0Q.valid;
    assign retireValid1 = slot1Q.valid;
    assign rename.slot0 = slot0Q;
    assign rename.slot1 = slot1Q;

endmodule

`default_nettype wire

/* rtl/interruptSampler.sv */
`timescale 1ns/1ps
`default_nettype none

module interruptSampler (
    input  wire       clk,
    input  wire       rst,
    input  wire [5:0] extInt,
    input  wire [5:0] statusIm,
    input  wire       statusIe,
    input  wire       statusExl,
    output logic      intPending
);

    logic [5:0] lineQ;
    logic [5:0] maskQ;
    logic       enableQ;

    // Lines and status are sampled together.
    always_ff @(posedge clk) begin
        if (rst) begin
            lineQ   <= '0;
            maskQ   <= '0;
            enableQ <= 1'b0;
        end else begin
            lineQ   <= extInt;
            maskQ   <= statusIm;
            enableQ <= statusIe && !statusExl;
        end
    end

    assign intPending = enableQ && (|(lineQ & maskQ));

endmodule

`default_nettype wire

/* rtl/robQueue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "commit_macros.svh"

module robQueue (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         enqValid,
    input  wire commitPkg::robEntry_t   enqEntry,
    output commitPkg::robTag_t          enqTag,
    output logic                        robFull,
    input  wire                         cmpValid,
    input  wire commitPkg::robTag_t     cmpTag,
    input  wire                         cmpTaken,
    input  wire [31:0]                  cmpTarget,
    input  wire commitPkg::excCode_t    cmpExc,
    robHeadIf.rob                       head
);

    commitPkg::robEntry_t rob [`ROB_DEPTH];
    commitPkg::robTag_t   headPtr;
    commitPkg::robTag_t   tailPtr;
    commitPkg::robTag_t   headNext;
    commitPkg::robTag_t   cmpOffset;
    logic [`TAG_BITS:0]   count;
    logic                 enqDo;
    logic                 cmpDo;

    assign robFull  = (count == (`TAG_BITS+1)'(`ROB_DEPTH));
    assign enqTag   = tailPtr;
    assign enqDo    = enqValid && !robFull && !head.flush;
    assign headNext = headPtr + 1'b1;

    // Ignore completions for tags that are no longer in flight.
    assign cmpOffset = cmpTag - headPtr;
    assign cmpDo     = cmpValid && !head.flush && ({1'b0, cmpOffset} < count);

    assign head.head0      = rob[headPtr];
    assign head.head1      = rob[headNext];
    assign head.head0Valid = (count != '0) && rob[headPtr].valid;
    assign head.head1Valid = (count > (`TAG_BITS+1)'(1)) && rob[headNext].valid;

    always_ff @(posedge clk) begin
        if (enqDo) begin
            rob[tailPtr]       <= enqEntry;
            rob[tailPtr].valid <= 1'b1;
            rob[tailPtr].done  <= 1'b0;
        end
        if (cmpDo) begin
            rob[cmpTag].done         <= 1'b1;
            rob[cmpTag].actualTaken  <= cmpTaken;
            rob[cmpTag].actualTarget <= cmpTarget;
            rob[cmpTag].exc          <= cmpExc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else if (head.flush) begin
            // Flush empties the buffer and beats pop and enqueue.
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else begin
            headPtr <= headPtr + commitPkg::robTag_t'(head.retireCount);
            if (enqDo) begin
                tailPtr <= tailPtr + 1'b1;
            end
            count <= count + (`TAG_BITS+1)'(enqDo)
                           - (`TAG_BITS+1)'(head.retireCount);
        end
    end

endmodule

`default_nettype wire

/* rtl/renameCommitIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface renameCommitIf;

    // Slot 1 is younger than slot 0.
    commitPkg::retireSlot_t slot0;
    commitPkg::retireSlot_t slot1;

    modport ctrl (
        output slot0, slot1
    );

    modport map (
        input slot0, slot1
    );

endinterface

`default_nettype wire

/* rtl/robHeadIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface robHeadIf;

    commitPkg::robEntry_t head0;
    commitPkg::robEntry_t head1;
    logic                 head0Valid;
    logic                 head1Valid;
    // Number of entries popped at the next edge.
    logic [1:0]           retireCount;
    logic                 flush;

    modport rob (
        output head0, head1, head0Valid, head1Valid,
        input  retireCount, flush
    );

    modport ctrl (
        input  head0, head1, head0Valid, head1Valid,
        output retireCount, flush
    );

endinterface

`default_nettype wire

/* rtl/commitPkg.sv */
`default_nettype none

`include "commit_macros.svh"

package commitPkg;

    typedef logic [`TAG_BITS-1:0] robTag_t;
    typedef logic [$clog2(`ARCH_REGS)-1:0] archReg_t;
    typedef logic [`PHYS_BITS-1:0] physReg_t;

    // Cause codes as reported on excCode.
    typedef enum logic [4:0] {
        excNone      = 5'd0,
        excInterrupt = 5'd1,
        excAddrErr   = 5'd4,
        excSyscall   = 5'd8,
        excOverflow  = 5'd12
    } excCode_t;

    typedef struct packed {
        logic        valid;
        logic        done;
        logic [31:0] pc;
        logic        isBranch;
        logic        predTaken;
        logic [31:0] predTarget;
        // Filled in on completion.
        logic        actualTaken;
        logic [31:0] actualTarget;
        logic        dstWe;
        archReg_t    dstArch;
        physReg_t    dstPhys;
        excCode_t    exc;
    } robEntry_t;

    // One register write leaving the commit stage.
    typedef struct packed {
        logic     valid;
        logic     we;
        archReg_t arch;
        physReg_t phys;
    } retireSlot_t;

endpackage

`default_nettype wire

/* rtl/commit_macros.svh */
`ifndef COMMIT_MACROS_SVH
`define COMMIT_MACROS_SVH

// Reorder buffer size and tag width.
`define ROB_DEPTH 16
`define TAG_BITS 4

// Register file sizes.
`define ARCH_REGS 32
`define PHYS_BITS 6

// Fetch address for exceptions and interrupts.
`define EXC_VECTOR 32'hBFC00380

`endif
